// ==== design/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

//////////////////////////////////////////////////
// Line and frame timing, progressive PAL
//////////////////////////////////////////////////

// One pixel per clock, 64 us line
`define H_TOTAL 448
`define V_TOTAL 312   // Lines per frame, no interlace

// Active picture in the top left corner
`define ACT_W 256
`define ACT_H 192

// Horizontal sync pulse, h counts
`define HS_START 304
`define HS_END   336   // First pixel after the pulse

// Lines with inverted sync pulses
`define VS_START 248
`define VS_END   251   // First line after vertical sync

//////////////////////////////////////////////////
// Pattern writer
//////////////////////////////////////////////////

`define POKE_LINE 192         // First line below the picture
`define POKE_LAST 16'hBFFF    // Pointer wraps here, page steps on

`endif

// ==== design/video_pkg.sv ====
`default_nettype none

package video_pkg;

   //////////////////////////////////////////////////
   // Beam position and sync
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [8:0] h;        // Pixel within the line
      logic [8:0] v;        // Line within the frame
      logic       active;   // Inside the 256x192 picture
      logic       csync;    // Raw composite sync level
   } beam_t;

   // Colour at the pins with 3 bits per channel
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } rgb_t;

   //////////////////////////////////////////////////
   // SRAM access
   //////////////////////////////////////////////////

   // Same shape for reads and writes
   // A read leaves wdata at zero and we low
   typedef struct packed {
      logic [20:0] addr;    // Top bit zero above page 19..16 and offset 15..0
      logic [7:0]  wdata;
      logic        we;      // One cycle strobe
   } sram_req_t;

endpackage

`default_nettype wire

// ==== design/pal_timing.sv ====
`default_nettype none

`include "video_macros.svh"

module pal_timing (
   input  logic               clk,
   input  logic               rst,
   output video_pkg::beam_t   beam
);

   import video_pkg::*;

   logic       h_wrap;   // Last pixel of the line
   logic       v_wrap;   // Last line of the frame
   logic [8:0] h_nxt;
   logic [8:0] v_nxt;

   // Sync level for a given position
   function automatic logic sync_level(input logic [8:0] h, input logic [8:0] v);
      logic in_hs;
      logic in_vs;
      in_hs = (h >= `HS_START) && (h < `HS_END);
      in_vs = (v >= `VS_START) && (v < `VS_END);
      // Pulses flip polarity on vertical sync lines
      if (in_vs) begin
         return in_hs;
      end
      return ~in_hs;
   endfunction

   // Picture area flag
   function automatic logic in_picture(input logic [8:0] h, input logic [8:0] v);
      return (h < `ACT_W) && (v < `ACT_H);
   endfunction

   //////////////////////////////////////////////////
   // Next count
   //////////////////////////////////////////////////

   always_comb begin
      h_wrap = (beam.h == 9'(`H_TOTAL - 1));
      v_wrap = (beam.v == 9'(`V_TOTAL - 1));
      if (h_wrap) begin
         h_nxt = '0;
         v_nxt = v_wrap ? 9'd0 : beam.v + 9'd1;   // New line, maybe new frame
      end else begin
         h_nxt = beam.h + 9'd1;
         v_nxt = beam.v;
      end
   end

   //////////////////////////////////////////////////
   // Registered beam
   //////////////////////////////////////////////////

   // Flags are worked out from the next count
   // so they line up with h and v in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         beam.h      <= '0;
         beam.v      <= '0;
         beam.active <= in_picture(9'd0, 9'd0);   // Top left pixel
         beam.csync  <= sync_level(9'd0, 9'd0);   // High, no pulse there
      end else begin
         beam.h      <= h_nxt;
         beam.v      <= v_nxt;
         beam.active <= in_picture(h_nxt, v_nxt);
         beam.csync  <= sync_level(h_nxt, v_nxt);
      end
   end

endmodule

`default_nettype wire

// ==== design/pattern_writer.sv ====
`default_nettype none

`include "video_macros.svh"

module pattern_writer (
   input  logic                  clk,
   input  logic                  rst,
   input  video_pkg::beam_t      beam,
   output video_pkg::sram_req_t  wr_req,
   output logic [3:0]            page
);

   import video_pkg::*;

   logic [15:0] poke_ptr;    // Write pointer within the page
   logic        poke_slot;   // Visible part of the write line
   logic        poke_we;
   logic        poke_step;

   // Line 192, first 256 pixels, one byte per four pixels
   assign poke_slot = (beam.v == `POKE_LINE) && (beam.h < `ACT_W);
   assign poke_we   = poke_slot && (beam.h[1:0] == 2'b00);
   assign poke_step = poke_slot && (beam.h[1:0] == 2'b01);   // Write first, step after

   always_comb begin
      wr_req.addr  = {1'b0, page, poke_ptr};
      wr_req.wdata = poke_ptr[14:7];   // Pattern byte from pointer
      wr_req.we    = poke_we;
   end

   //////////////////////////////////////////////////
   // Pointer and page
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         poke_ptr <= '0;
         page     <= '0;
      end else if (poke_step) begin
         if (poke_ptr == `POKE_LAST) begin
            poke_ptr <= '0;
            page     <= page + 4'd1;   // Next 64K page, border changes too
         end else begin
            poke_ptr <= poke_ptr + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/sram_port_mux.sv ====
`default_nettype none

module sram_port_mux (
   input  logic                  clk,
   input  logic                  rst,
   input  video_pkg::sram_req_t  rd_req,
   input  video_pkg::sram_req_t  wr_req,
   output logic [7:0]            rd_data,
   output logic [20:0]           sram_addr,
   inout  wire  [7:0]            sram_data,
   output logic                  sram_we_n
);

   import video_pkg::*;

   sram_req_t sel;   // Request that owns the SRAM this cycle

   //////////////////////////////////////////////////
   // Port select
   //////////////////////////////////////////////////

   // A write strobe wins over the standing read
   // Writes fall on a line with no picture fetch
   always_comb begin
      if (wr_req.we) begin
         sel = wr_req;
      end else begin
         sel = rd_req;
      end
   end

   //////////////////////////////////////////////////
   // SRAM pins
   //////////////////////////////////////////////////

   assign sram_addr = sel.addr;
   assign sram_we_n = ~sel.we;   // Low for the write cycle only

   // Bus driven only while writing, released otherwise
   assign sram_data = sel.we ? sel.wdata : 8'bz;

   //////////////////////////////////////////////////
   // Read data capture
   //////////////////////////////////////////////////

   // Byte for this cycle's address shows up next cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data <= '0;
      end else if (!sel.we) begin
         rd_data <= sram_data;   // Hold last read across a write
      end
   end

endmodule

`default_nettype wire

// ==== design/frame_reader.sv ====
`default_nettype none

`include "video_macros.svh"

module frame_reader (
   input  logic                  clk,
   input  logic                  rst,
   input  video_pkg::beam_t      beam,
   input  logic [3:0]            page,
   input  logic [7:0]            rd_data,
   output video_pkg::sram_req_t  rd_req,
   output video_pkg::rgb_t       rgb,
   output logic                  csync
);

   import video_pkg::*;

   logic [15:0] vram_ptr;   // Read pointer within the page
   logic        act_d;      // Active flag, aligned with rd_data
   logic        csync_d;    // Sync, aligned with rd_data
   rgb_t        pix;        // Decoded colour before the pin register

   //////////////////////////////////////////////////
   // Read pointer
   //////////////////////////////////////////////////

   // One byte per active pixel, rewinds below the picture
   always_ff @(posedge clk) begin
      if (rst) begin
         vram_ptr <= '0;
      end else if (beam.v >= `ACT_H) begin
         vram_ptr <= '0;
      end else if (beam.active) begin
         vram_ptr <= vram_ptr + 16'd1;
      end
   end

   // Read request every cycle
   always_comb begin
      rd_req.addr  = {1'b0, page, vram_ptr};
      rd_req.wdata = '0;
      rd_req.we    = 1'b0;
   end

   //////////////////////////////////////////////////
   // Align with returning data
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         act_d   <= 1'b0;
         csync_d <= 1'b1;
      end else begin
         act_d   <= beam.active;
         csync_d <= beam.csync;
      end
   end

   //////////////////////////////////////////////////
   // Colour decode
   //////////////////////////////////////////////////

   always_comb begin
      if (act_d) begin
         // RGB 3-3-2 byte, green on top
         pix.g = rd_data[7:5];
         pix.r = rd_data[4:2];
         pix.b = {rd_data[1:0], rd_data[1]};   // Stretch blue to 3 bits
      end else begin
         // Border from page bits 3..1
         pix.g = {3{page[3]}};
         pix.r = {3{page[2]}};
         pix.b = {3{page[1]}};
      end
   end

   // Pin registers, colour and sync together
   always_ff @(posedge clk) begin
      if (rst) begin
         rgb   <= '0;
         csync <= 1'b1;
      end else begin
         rgb   <= pix;
         csync <= csync_d;
      end
   end

endmodule

`default_nettype wire

// ==== design/video_test_top.sv ====
`default_nettype none

module video_test_top (
   input  logic        clk,
   input  logic        rst,
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b,
   output logic        csync,
   output logic [20:0] sram_addr,
   inout  wire  [7:0]  sram_data,
   output logic        sram_we_n
);

   video_pkg::beam_t     beam;      // Beam position and raw sync
   video_pkg::sram_req_t rd_req;    // Picture fetch
   video_pkg::sram_req_t wr_req;    // Pattern write
   video_pkg::rgb_t      rgb;
   logic [3:0]           page;      // Shared page and border select
   logic [7:0]           rd_data;

   // Colour channels to the pins
   assign r = rgb.r;
   assign g = rgb.g;
   assign b = rgb.b;

   //////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////

   pal_timing i_pal_timing (
      .clk  (clk),
      .rst  (rst),
      .beam (beam)
   );

   pattern_writer i_pattern_writer (
      .clk    (clk),
      .rst    (rst),
      .beam   (beam),
      .wr_req (wr_req),
      .page   (page)
   );

   sram_port_mux i_sram_port_mux (
      .clk       (clk),
      .rst       (rst),
      .rd_req    (rd_req),
      .wr_req    (wr_req),
      .rd_data   (rd_data),
      .sram_addr (sram_addr),
      .sram_data (sram_data),
      .sram_we_n (sram_we_n)
   );

   frame_reader i_frame_reader (
      .clk     (clk),
      .rst     (rst),
      .beam    (beam),
      .page    (page),
      .rd_data (rd_data),
      .rd_req  (rd_req),
      .rgb     (rgb),
      .csync   (csync)
   );

endmodule

`default_nettype wire

// ==== bench/sram_model.sv ====
`default_nettype none

module sram_model (
   input  wire [20:0] addr,
   inout  wire [7:0]  data,
   input  wire        we_n
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] mem [0:(1 << 21) - 1];   // 2M x 8

   // Output enabled whenever no write is under way
   assign data = we_n ? mem[addr] : 8'bz;

   //////////////////////////////////////////////////
   // Write cycle
   //////////////////////////////////////////////////

   // Address and data settle after the strobe edge
   always begin
      @(negedge we_n);
      #1;
      if (!we_n) begin
         mem[addr] = data;
      end
   end

   // Backdoor load, no bus cycle
   task automatic preload(input logic [20:0] a, input logic [7:0] d);
      mem[a] = d;
   endtask

endmodule

`default_nettype wire

// ==== bench/video_test_tb.sv ====
`default_nettype none

`include "video_macros.svh"

module video_test_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int PIXEL  = 0;
   localparam int BORDER = 1;
   localparam int SYNC   = 2;
   localparam int WAIT_LIMIT = 3 * `H_TOTAL * `V_TOTAL;   // Three frames

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        csync;
   logic [20:0] sram_addr;
   wire  [7:0]  sram_data;
   logic        sram_we_n;

   logic [7:0]  shadow [0:65535];   // Page 0 as it should read back

   // Table of sample points
   string       names[$];
   int          t_frame[$];
   int          t_h[$];
   int          t_v[$];
   int          t_kind[$];

   // Beam tracker updated on the falling clock edge
   int          clk_cnt;
   int          frame;        // Frame of the last line start
   int          line;         // Line of the last line start
   int          fall_clk;     // Clock of the last line start
   int          last_ord_clk;
   int          run_len;      // Clocks at the current csync level
   int          vs_pulses;
   int          vs_checks;
   int          gap;
   logic        prev_cs;
   logic        vs_seen;
   logic        ord_low;      // Low phase follows an ordinary line start
   int          wr_count;     // Strobes in this frame
   int          wr_frames;
   int          last_wr_clk;
   int          total;
   logic [20:0] exp_addr;
   int          sync_errs;
   int          write_errs;

   int          tests_run;
   int          tests_failed;
   int          seed_val;
   int          a;
   int          n;
   int          lows;
   bit          aborted;

   always #5 clk = ~clk;

   video_test_top i_video_test_top (
      .clk       (clk),
      .rst       (rst),
      .r         (r),
      .g         (g),
      .b         (b),
      .csync     (csync),
      .sram_addr (sram_addr),
      .sram_data (sram_data),
      .sram_we_n (sram_we_n)
   );

   sram_model i_sram_model (
      .addr (sram_addr),
      .data (sram_data),
      .we_n (sram_we_n)
   );

   //////////////////////////////////////////////////
   // Expected values
   //////////////////////////////////////////////////

   function automatic logic exp_sync(input int h, input int v);
      logic in_hs;
      in_hs = (h >= `HS_START) && (h < `HS_END);
      if ((v >= `VS_START) && (v < `VS_END)) begin
         return in_hs;   // Inverted on vertical sync lines
      end
      return !in_hs;
   endfunction

   // RGB 3-3-2 byte to {r, g, b}
   function automatic logic [8:0] decode_byte(input logic [7:0] d);
      return {d[4:2], d[7:5], d[1:0], d[1]};
   endfunction

   function automatic logic [8:0] border_rgb(input int f, input int v);
      int         done;
      logic [3:0] p;
      done = (`ACT_W / 4) * ((v > `POKE_LINE) ? f + 1 : f);   // Writes before this line
      p = 4'(done / (`POKE_LAST + 1));
      return {{3{p[2]}}, {3{p[3]}}, {3{p[1]}}};
   endfunction

   task automatic add_row(input string nm, input int f, input int h, input int v, input int k);
      names.push_back(nm);
      t_frame.push_back(f);
      t_h.push_back(h);
      t_v.push_back(v);
      t_kind.push_back(k);
   endtask

   //////////////////////////////////////////////////
   // Line tracker and write monitor
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rst) begin
         clk_cnt      = 0;
         frame        = -1;
         line         = `V_TOTAL - 1;   // First line start is line 0
         last_ord_clk = -1;
         run_len      = 0;
         prev_cs      = 1'b1;
         vs_seen      = 1'b0;
         ord_low      = 1'b0;
         wr_count     = 0;
      end else begin
         clk_cnt++;
         if (csync === prev_cs) begin
            run_len++;
         end else if (!csync && run_len >= `HS_START) begin
            // Ordinary falling edge marks HS_START
            if (last_ord_clk >= 0) begin
               gap = vs_seen ? (`VS_END - `VS_START + 1) * `H_TOTAL : `H_TOTAL;
               if (clk_cnt - last_ord_clk != gap) begin
                  $display("Error sync_period: expected %0d, actual %0d", gap,
                           clk_cnt - last_ord_clk);
                  sync_errs++;
               end
            end
            if (vs_seen) begin
               if (vs_pulses != `VS_END - `VS_START) begin
                  $display("Error sync_vs_lines: expected %0d, actual %0d",
                           `VS_END - `VS_START, vs_pulses);
                  sync_errs++;
               end
               vs_checks++;
               vs_seen = 1'b0;
               line    = `VS_END;
            end else if (line == `V_TOTAL - 1) begin
               // New frame so the last one's writes are complete
               if (frame >= 0) begin
                  if (wr_count != `ACT_W / 4) begin
                     $display("Error write_strobes: expected %0d per frame, actual %0d",
                              `ACT_W / 4, wr_count);
                     write_errs++;
                  end
                  wr_frames++;
               end
               frame++;
               line     = 0;
               wr_count = 0;
            end else begin
               line++;
            end
            fall_clk     = clk_cnt;
            last_ord_clk = clk_cnt;
            ord_low      = 1'b1;
            run_len      = 1;
         end else if (!csync && run_len == `HS_END - `HS_START) begin
            vs_pulses++;   // Short high pulse of an inverted line
            ord_low = 1'b0;
            run_len = 1;
         end else if (!csync) begin
            // Start of vertical sync
            if (line != `VS_START - 1) begin
               $display("Error sync_vs_start: expected line %0d, actual %0d",
                        `VS_START - 1, line);
               sync_errs++;
            end
            vs_seen   = 1'b1;
            vs_pulses = 0;
            ord_low   = 1'b0;
            run_len   = 1;
         end else begin
            if (ord_low && run_len != `HS_END - `HS_START) begin
               $display("Error sync_width: expected %0d, actual %0d",
                        `HS_END - `HS_START, run_len);
               sync_errs++;
            end
            run_len = 1;
         end
         prev_cs = csync;

         if (sram_we_n === 1'b0) begin
            total    = (`ACT_W / 4) * frame + wr_count;
            exp_addr = {1'b0, 4'(total / (`POKE_LAST + 1)), 16'(total % (`POKE_LAST + 1))};
            if (sram_addr !== exp_addr || sram_data !== exp_addr[14:7]) begin
               $display("Error write_strobes: expected addr %h data %h, actual addr %h data %h",
                        exp_addr, exp_addr[14:7], sram_addr, sram_data);
               write_errs++;
            end
            if (wr_count > 0 && clk_cnt - last_wr_clk != 4) begin
               $display("Error write_strobes: expected spacing 4, actual %0d",
                        clk_cnt - last_wr_clk);
               write_errs++;
            end
            if (exp_addr[20:16] == 5'd0) begin
               shadow[exp_addr[15:0]] = exp_addr[14:7];
            end
            last_wr_clk = clk_cnt;
            wr_count++;
         end
      end
   end

   //////////////////////////////////////////////////
   // Sampling
   //////////////////////////////////////////////////

   // Polls on the rising edge and returns on the falling edge of the target clock
   task automatic wait_sample(input int rf, input int rl, input int off, output bit ok);
      int cnt;
      ok  = 1'b0;
      cnt = 0;
      while (!ok && cnt < WAIT_LIMIT) begin
         @(posedge clk);
         cnt++;
         if (frame == rf && line == rl && clk_cnt == fall_clk + off - 1) begin
            ok = 1'b1;
         end
      end
      if (ok) begin
         @(negedge clk);
      end
   endtask

   task automatic check_row(input int idx);
      int         f;
      int         h;
      int         v;
      int         rf;
      int         rl;
      int         off;
      bit         ok;
      logic [8:0] exp_rgb;
      logic       exp_cs;
      f = t_frame[idx];
      h = t_h[idx];
      v = t_v[idx];
      // Reference is the line start just before the pixel
      if (h >= `HS_START) begin
         rf  = f;
         rl  = v;
         off = h - `HS_START;
      end else begin
         rf  = (v == 0) ? f - 1 : f;
         rl  = (v == 0) ? `V_TOTAL - 1 : v - 1;
         off = h + `H_TOTAL - `HS_START;
      end
      wait_sample(rf, rl, off, ok);
      tests_run++;
      if (!ok) begin
         $display("%s: timed out waiting for its line start", names[idx]);
         tests_failed++;
         aborted = 1'b1;
      end else begin
         if (t_kind[idx] == PIXEL) begin
            exp_rgb = decode_byte(shadow[v * `ACT_W + h]);
         end else begin
            exp_rgb = border_rgb(f, v);
         end
         exp_cs = exp_sync(h, v);
         if ({r, g, b} !== exp_rgb || csync !== exp_cs) begin
            $display("Error %s: expected rgb %o csync %b, actual rgb %o csync %b",
                     names[idx], exp_rgb, exp_cs, {r, g, b}, csync);
            tests_failed++;
         end else begin
            $display("%s: ok", names[idx]);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      seed_val = $urandom(83472);
      for (a = 0; a < 65536; a++) begin
         shadow[a] = 8'($urandom);
         i_sram_model.preload(21'(a), shadow[a]);
      end

      // Name, frame, h, v and kind of each sample point
      add_row("pix_f0_row2_left",  0,   5,   2, PIXEL);
      add_row("pix_f0_row2_right", 0, 255,   2, PIXEL);
      add_row("pix_f0_mid",        0, 128, 100, PIXEL);
      add_row("border_f0_right",   0, 300, 100, BORDER);
      add_row("sync_f0_hpulse",    0, 320, 100, SYNC);
      add_row("pix_f0_last_left",  0,   0, 191, PIXEL);
      add_row("pix_f0_last_right", 0, 255, 191, PIXEL);
      add_row("border_f0_poke",    0,  10, 192, BORDER);
      add_row("sync_f0_vs_low",    0, 100, 248, SYNC);
      add_row("border_f0_bottom",  0, 200, 300, BORDER);
      add_row("pix_f1_written_a",  1,  10,   0, PIXEL);   // Written in frame 0
      add_row("pix_f1_written_b",  1,  63,   0, PIXEL);
      add_row("pix_f1_unwritten",  1,  64,   0, PIXEL);
      add_row("pix_f1_preload",    1, 150,   0, PIXEL);
      add_row("pix_f1_row50",      1,  20,  50, PIXEL);
      add_row("pix_f2_written",    2, 100,   0, PIXEL);
      add_row("pix_f2_unwritten",  2, 130,   0, PIXEL);
      add_row("pix_f3_written_a",  3, 130,   0, PIXEL);   // Data 1 from frame 2
      add_row("pix_f3_written_b",  3, 191,   0, PIXEL);
      add_row("pix_f3_unwritten",  3, 200,   0, PIXEL);
      add_row("pix_f3_row60",      3, 250,  60, PIXEL);
      add_row("border_f3_right",   3, 400, 191, BORDER);

      repeat (10) begin
         @(posedge clk);
      end
      rst <= 1'b0;

      // Still in reset at this edge
      @(negedge clk);
      tests_run++;
      if (csync !== 1'b1 || {r, g, b} !== 9'd0 || sram_we_n !== 1'b1) begin
         $display(
            "Error reset_state: expected csync 1 rgb 000 we_n 1, actual csync %b rgb %o we_n %b",
            csync, {r, g, b}, sram_we_n);
         tests_failed++;
      end else begin
         $display("reset_state: ok");
      end

      lows = 0;
      for (n = 0; n < `H_TOTAL; n++) begin
         @(negedge clk);
         if (sram_we_n !== 1'b1) begin
            lows++;
         end
      end
      tests_run++;
      if (lows != 0) begin
         $display("Error first_line_no_write: expected 0 strobes, actual %0d", lows);
         tests_failed++;
      end else begin
         $display("first_line_no_write: ok");
      end

      for (a = 0; a < names.size() && !aborted; a++) begin
         check_row(a);
      end

      // Tracker settles on the falling edge
      @(posedge clk);

      tests_run++;
      if (vs_checks == 0) begin
         $display("sync_shape: no complete vertical sync was seen");
         tests_failed++;
      end else if (sync_errs != 0) begin
         $display("sync_shape: FAIL with %0d errors", sync_errs);
         tests_failed++;
      end else begin
         $display("sync_shape: ok");
      end

      tests_run++;
      if (wr_frames == 0) begin
         $display("write_strobes: no frame of writes was completed");
         tests_failed++;
      end else if (write_errs != 0) begin
         $display("write_strobes: FAIL with %0d errors", write_errs);
         tests_failed++;
      end else begin
         $display("write_strobes: ok");
      end

      $display("Summary: %0d tests, %0d ok, %0d bad", tests_run, tests_run - tests_failed,
               tests_failed);
      if (tests_failed == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/video_pkg.sv
design/pal_timing.sv
design/pattern_writer.sv
design/sram_port_mux.sv
design/frame_reader.sv
design/video_test_top.sv
bench/sram_model.sv
bench/video_test_tb.sv
